/* src.f */
+incdir+source
source/pwr_pkg.sv
source/pwr_wait_timer.sv
source/pwr_domain_ctrl.sv
source/pwr_seq_fsm.sv
source/pwr_ctrl_top.sv
verification/switch_cell_model.sv
verification/tb_pwr_ctrl.sv

/* Bender.yml */
package:
  name: pwr_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/pwr_pkg.sv
      - source/pwr_wait_timer.sv
      - source/pwr_domain_ctrl.sv
      - source/pwr_seq_fsm.sv
      - source/pwr_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/switch_cell_model.sv
      - verification/tb_pwr_ctrl.sv

/* verification/tb_pwr_ctrl.sv */
//////////////////////////////////////////////////
// Testbench for the power-gating controller
// Directed and random commands against a model
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module tb_pwr_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS        = 61;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 200 + 100;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        req;
  pwr_pkg::pwr_cmd_t           cmd;
  logic                        ack;
  pwr_pkg::pwr_rsp_t           rsp;
  pwr_pkg::pwr_dom_ctrl_t      dom_ctrl;
  logic [`PWR_NUM_DOMAINS-1:0] switch_ack;
  logic                        stuck_en;
  logic [`PWR_DOM_W-1:0]       stuck_dom;
  pwr_pkg::pwr_dom_ctrl_t      ref_ctrl;
  logic [31:0]                 lcg_state = 32'h3aa4_fbaa;

  always #2 clk = ~clk;

  pwr_ctrl_top pwr_ctrl_top_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .cmd_i       (cmd),
    .ack_o       (ack),
    .rsp_o       (rsp),
    .dom_ctrl_o  (dom_ctrl),
    .switch_ack_i(switch_ack)
  );

  switch_cell_model #(.DELAY(10)) switch_cell_model_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .switch_en_i (dom_ctrl.switch_en),
    .stuck_en_i  (stuck_en),
    .stuck_dom_i (stuck_dom),
    .switch_ack_o(switch_ack)
  );

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_rsp(input string test, input pwr_pkg::pwr_rsp_t exp,
                           input pwr_pkg::pwr_rsp_t act);
    if (act !== exp) begin
      $display("Error: %s rsp expected status %0d powered %0b, actual status %0d powered %0b",
               test, exp.status, exp.powered, act.status, act.powered);
      end_with_failure();
    end
  endtask

  task automatic check_ctrl(input string test, input pwr_pkg::pwr_dom_ctrl_t exp,
                            input pwr_pkg::pwr_dom_ctrl_t act);
    if (act !== exp) begin
      $display("Error: %s dom_ctrl expected %h actual %h", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s latency expected %0d actual %0d", test, exp, act);
      end_with_failure();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected response; ref_ctrl moves to the state after the command
  function automatic pwr_pkg::pwr_rsp_t model_cmd(input pwr_pkg::pwr_op_e op,
                                                  input logic [`PWR_DOM_W-1:0] d);
    pwr_pkg::pwr_rsp_t exp;
    logic              on;
    on          = ref_ctrl.switch_en[d];
    exp.status  = pwr_pkg::PWR_ST_OK;
    exp.powered = on;
    case (op)
      pwr_pkg::PWR_OP_ON: begin
        if (!on && stuck_en && stuck_dom == d) begin
          exp.status = pwr_pkg::PWR_ST_TIMEOUT;
        end else if (!on) begin
          ref_ctrl.switch_en[d] = 1'b1;
          ref_ctrl.iso[d]       = 1'b0;
          ref_ctrl.rst_n[d]     = 1'b1;
          exp.powered           = 1'b1;
        end
      end
      pwr_pkg::PWR_OP_OFF: begin
        ref_ctrl.switch_en[d] = 1'b0;
        ref_ctrl.iso[d]       = 1'b1;
        ref_ctrl.rst_n[d]     = 1'b0;
        ref_ctrl.retentive[d] = 1'b0;
        exp.powered           = 1'b0;
      end
      default: begin
        if (!on) begin
          exp.status = pwr_pkg::PWR_ST_REFUSED;
        end else begin
          ref_ctrl.retentive[d] = (op == pwr_pkg::PWR_OP_RET_SET);
        end
      end
    endcase
    return exp;
  endfunction

  // Four-phase handshake, req held for extra cycles after ack
  task automatic send_cmd(input pwr_pkg::pwr_op_e op, input logic [`PWR_DOM_W-1:0] d,
                          input int extra, output pwr_pkg::pwr_rsp_t got, output int cycles);
    @(posedge clk);
    req        <= 1'b1;
    cmd.op     <= op;
    cmd.domain <= d;
    cycles = 0;
    @(negedge clk);
    while (!ack) begin
      cycles++;
      @(negedge clk);
    end
    got = rsp;
    repeat (extra) begin
      @(negedge clk);
      if (!ack || rsp !== got) begin
        $display("ack_o or rsp_o changed while req_i was still high");
        end_with_failure();
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack) begin
      @(negedge clk);
    end
  endtask

  task automatic run_cmd(input string test, input pwr_pkg::pwr_op_e op,
                         input logic [`PWR_DOM_W-1:0] d, input int extra, output int cycles);
    pwr_pkg::pwr_rsp_t exp;
    pwr_pkg::pwr_rsp_t got;
    exp = model_cmd(op, d);
    send_cmd(op, d, extra, got, cycles);
    check_rsp(test, exp, got);
    check_ctrl(test, ref_ctrl, dom_ctrl);
  endtask

  // Records when each line of domain d first leaves its starting level
  task automatic run_watched(input string test, input pwr_pkg::pwr_op_e op,
                             input logic [`PWR_DOM_W-1:0] d,
                             output time t_sw, output time t_ack,
                             output time t_rst, output time t_iso);
    pwr_pkg::pwr_dom_ctrl_t start;
    logic                   ack0;
    logic                   done;
    int                     cycles;
    start = dom_ctrl;
    ack0  = switch_ack[d];
    done  = 1'b0;
    t_sw  = 0;
    t_ack = 0;
    t_rst = 0;
    t_iso = 0;
    fork
      begin
        run_cmd(test, op, d, 0, cycles);
        done = 1'b1;
      end
      begin
        while (!done) begin
          @(negedge clk);
          if (t_sw == 0 && dom_ctrl.switch_en[d] != start.switch_en[d]) t_sw = $time;
          if (t_ack == 0 && switch_ack[d] != ack0) t_ack = $time;
          if (t_rst == 0 && dom_ctrl.rst_n[d] != start.rst_n[d]) t_rst = $time;
          if (t_iso == 0 && dom_ctrl.iso[d] != start.iso[d]) t_iso = $time;
        end
      end
    join
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_ctrl("reset", ref_ctrl, dom_ctrl);
    if (ack !== 1'b0) begin
      $display("ack_o is not low after reset");
      end_with_failure();
    end
  endtask

  task automatic test_on_off();
    int cycles;
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      run_cmd("power on", pwr_pkg::PWR_OP_ON, `PWR_DOM_W'(d), 0, cycles);
    end
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      run_cmd("power off", pwr_pkg::PWR_OP_OFF, `PWR_DOM_W'(d), 0, cycles);
    end
  endtask

  task automatic test_order();
    time t_sw;
    time t_ack;
    time t_rst;
    time t_iso;
    run_watched("order on", pwr_pkg::PWR_OP_ON, 2'd1, t_sw, t_ack, t_rst, t_iso);
    if (!(t_sw != 0 && t_sw < t_ack && t_ack < t_rst && t_rst < t_iso)) begin
      $display("Power-on of domain 1 changed its lines in the wrong order");
      end_with_failure();
    end
    run_watched("order off", pwr_pkg::PWR_OP_OFF, 2'd1, t_sw, t_ack, t_rst, t_iso);
    if (!(t_iso != 0 && t_iso < t_rst && t_rst < t_sw)) begin
      $display("Power-off of domain 1 changed its lines in the wrong order");
      end_with_failure();
    end
  endtask

  task automatic test_retention();
    int cycles;
    run_cmd("retention on", pwr_pkg::PWR_OP_ON, 2'd2, 0, cycles);
    run_cmd("retention set", pwr_pkg::PWR_OP_RET_SET, 2'd2, 0, cycles);
    check_count("retention set", 2, cycles);
    run_cmd("retention clear", pwr_pkg::PWR_OP_RET_CLR, 2'd2, 1, cycles);
    check_count("retention clear", 2, cycles);
    run_cmd("retention set", pwr_pkg::PWR_OP_RET_SET, 2'd2, 0, cycles);
    // Power-off drops retention with the supply
    run_cmd("retention off", pwr_pkg::PWR_OP_OFF, 2'd2, 0, cycles);
    run_cmd("refused set", pwr_pkg::PWR_OP_RET_SET, 2'd2, 0, cycles);
    check_count("refused set", 2, cycles);
    run_cmd("refused clear", pwr_pkg::PWR_OP_RET_CLR, 2'd0, 2, cycles);
    check_count("refused clear", 2, cycles);
  endtask

  task automatic test_stuck_and_repeat();
    int cycles;
    @(posedge clk);
    stuck_en  <= 1'b1;
    stuck_dom <= 2'd3;
    @(negedge clk);
    run_cmd("stuck on", pwr_pkg::PWR_OP_ON, 2'd3, 0, cycles);
    run_cmd("repeat off", pwr_pkg::PWR_OP_OFF, 2'd3, 0, cycles);
    run_cmd("power on", pwr_pkg::PWR_OP_ON, 2'd0, 0, cycles);
    run_cmd("repeat on", pwr_pkg::PWR_OP_ON, 2'd0, 1, cycles);
    @(posedge clk);
    stuck_en <= 1'b0;
    @(negedge clk);
  endtask

  task automatic test_random();
    logic [31:0] r;
    int          cycles;
    for (int n = 0; n < 40; n++) begin
      r = lcg_next();
      run_cmd($sformatf("random %0d", n), pwr_pkg::pwr_op_e'(r[21:20]), r[17:16],
              int'(r[25:24]), cycles);
    end
  endtask

  initial begin
    rst                = 1'b1;
    req                = 1'b0;
    cmd                = '0;
    stuck_en           = 1'b0;
    stuck_dom          = '0;
    ref_ctrl.switch_en = '0;
    ref_ctrl.iso       = '1;
    ref_ctrl.rst_n     = '0;
    ref_ctrl.retentive = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_on_off();
    test_order();
    test_retention();
    test_stuck_and_repeat();
    test_random();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired: the controller stopped answering commands");
    end_with_failure();
  end

endmodule

`default_nettype wire

/* verification/switch_cell_model.sv */
//////////////////////////////////////////////////
// Switch cell model
// Echoes each switch line after a fixed delay
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module switch_cell_model #(
  parameter int DELAY = 10
) (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire [`PWR_NUM_DOMAINS-1:0]   switch_en_i,
  input  wire                          stuck_en_i,
  input  wire [`PWR_DOM_W-1:0]         stuck_dom_i,
  output logic [`PWR_NUM_DOMAINS-1:0]  switch_ack_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`PWR_NUM_DOMAINS-1:0] line_q [DELAY];
  logic [`PWR_NUM_DOMAINS-1:0] stuck_mask;

  // A stuck cell never reports its switch as closed
  assign stuck_mask = stuck_en_i ? (`PWR_NUM_DOMAINS'(1) << stuck_dom_i) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < DELAY; i++) begin
        line_q[i] <= '0;
      end
    end else begin
      line_q[0] <= switch_en_i & ~stuck_mask;
      for (int i = 1; i < DELAY; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  assign switch_ack_o = line_q[DELAY-1];

endmodule

`default_nettype wire

/* source/pwr_ctrl_top.sv */
//////////////////////////////////////////////////
// Power-gating controller top
// FSM, wait timer and domain bank
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module pwr_ctrl_top (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          req_i,
  input  pwr_pkg::pwr_cmd_t            cmd_i,
  output logic                         ack_o,
  output pwr_pkg::pwr_rsp_t            rsp_o,
  output pwr_pkg::pwr_dom_ctrl_t       dom_ctrl_o,
  input  wire [`PWR_NUM_DOMAINS-1:0]   switch_ack_i
);

  pwr_pkg::pwr_step_e          step;
  logic [`PWR_DOM_W-1:0]       step_dom;
  logic [`PWR_NUM_DOMAINS-1:0] ack_sync;
  logic                        tmr_start;
  logic [`PWR_TMR_W-1:0]       tmr_count;
  logic                        tmr_done;

  pwr_seq_fsm pwr_seq_fsm_i (
    .clk_i,
    .rst_i,
    .req_i,
    .cmd_i,
    .ack_o,
    .rsp_o,
    .step_o     (step),
    .step_dom_o (step_dom),
    .dom_ctrl_i (dom_ctrl_o),
    .ack_sync_i (ack_sync),
    .tmr_start_o(tmr_start),
    .tmr_count_o(tmr_count),
    .tmr_done_i (tmr_done)
  );

  pwr_wait_timer pwr_wait_timer_i (
    .clk_i,
    .rst_i,
    .start_i(tmr_start),
    .count_i(tmr_count),
    .done_o (tmr_done)
  );

  pwr_domain_ctrl pwr_domain_ctrl_i (
    .clk_i,
    .rst_i,
    .step_i      (step),
    .dom_i       (step_dom),
    .switch_ack_i,
    .ack_sync_o  (ack_sync),
    .dom_ctrl_o
  );

endmodule

`default_nettype wire

/* source/pwr_seq_fsm.sv */
//////////////////////////////////////////////////
// Power sequencing FSM
// Runs one command and answers the req/ack port
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module pwr_seq_fsm (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          req_i,
  input  pwr_pkg::pwr_cmd_t            cmd_i,
  output logic                         ack_o,
  output pwr_pkg::pwr_rsp_t            rsp_o,
  output pwr_pkg::pwr_step_e           step_o,
  output logic [`PWR_DOM_W-1:0]        step_dom_o,
  input  pwr_pkg::pwr_dom_ctrl_t       dom_ctrl_i,
  input  wire [`PWR_NUM_DOMAINS-1:0]   ack_sync_i,
  output logic                         tmr_start_o,
  output logic [`PWR_TMR_W-1:0]        tmr_count_o,
  input  wire                          tmr_done_i
);

  // Timer loads count one less than the wait it produces
  localparam logic [`PWR_TMR_W-1:0] ISO_CNT = `PWR_TMR_W'(`PWR_ISO_WAIT - 1);
  localparam logic [`PWR_TMR_W-1:0] RST_CNT = `PWR_TMR_W'(`PWR_RST_WAIT - 1);
  localparam logic [`PWR_TMR_W-1:0] ACK_CNT = `PWR_TMR_W'(`PWR_ACK_TIMEOUT);

  pwr_pkg::pwr_fsm_e    state_q;
  pwr_pkg::pwr_fsm_e    state_d;
  pwr_pkg::pwr_cmd_t    cmd_q;
  pwr_pkg::pwr_rsp_t    rsp_q;
  pwr_pkg::pwr_status_e status_d;
  logic                 rsp_load;
  logic                 powered_d;
  logic                 dom_pwr;
  logic                 dom_ack;

  assign dom_pwr = dom_ctrl_i.switch_en[cmd_q.domain];
  assign dom_ack = ack_sync_i[cmd_q.domain];

  always_comb begin
    state_d     = state_q;
    step_o      = pwr_pkg::STEP_NONE;
    tmr_start_o = 1'b0;
    tmr_count_o = '0;
    rsp_load    = 1'b0;
    status_d    = pwr_pkg::PWR_ST_OK;

    case (state_q)
      pwr_pkg::FSM_IDLE: begin
        if (req_i) begin
          state_d = pwr_pkg::FSM_DECIDE;
        end
      end

      pwr_pkg::FSM_DECIDE: begin
        case (cmd_q.op)
          pwr_pkg::PWR_OP_OFF: begin
            if (!dom_pwr) begin
              state_d  = pwr_pkg::FSM_ACK;
              rsp_load = 1'b1;
            end else begin
              step_o      = pwr_pkg::STEP_ISO_SET;
              tmr_start_o = 1'b1;
              tmr_count_o = ISO_CNT;
              state_d     = pwr_pkg::FSM_OFF_ISO_WAIT;
            end
          end
          pwr_pkg::PWR_OP_ON: begin
            if (dom_pwr) begin
              state_d  = pwr_pkg::FSM_ACK;
              rsp_load = 1'b1;
            end else begin
              step_o      = pwr_pkg::STEP_SW_ON;
              tmr_start_o = 1'b1;
              tmr_count_o = ACK_CNT;
              state_d     = pwr_pkg::FSM_ON_ACK_WAIT;
            end
          end
          default: begin
            // Retention only on a powered domain
            if (!dom_pwr) begin
              status_d = pwr_pkg::PWR_ST_REFUSED;
            end else if (cmd_q.op == pwr_pkg::PWR_OP_RET_SET) begin
              step_o = pwr_pkg::STEP_RET_SET;
            end else begin
              step_o = pwr_pkg::STEP_RET_CLR;
            end
            state_d  = pwr_pkg::FSM_ACK;
            rsp_load = 1'b1;
          end
        endcase
      end

      pwr_pkg::FSM_ON_ACK_WAIT: begin
        if (dom_ack) begin
          tmr_start_o = 1'b1;
          tmr_count_o = RST_CNT;
          state_d     = pwr_pkg::FSM_ON_RST_WAIT;
        end else if (tmr_done_i) begin
          step_o   = pwr_pkg::STEP_OFF_SAFE;
          status_d = pwr_pkg::PWR_ST_TIMEOUT;
          state_d  = pwr_pkg::FSM_ACK;
          rsp_load = 1'b1;
        end
      end

      pwr_pkg::FSM_ON_RST_WAIT: begin
        if (tmr_done_i) begin
          step_o      = pwr_pkg::STEP_RST_RELEASE;
          tmr_start_o = 1'b1;
          tmr_count_o = ISO_CNT;
          state_d     = pwr_pkg::FSM_ON_ISO_WAIT;
        end
      end

      pwr_pkg::FSM_ON_ISO_WAIT: begin
        if (tmr_done_i) begin
          step_o   = pwr_pkg::STEP_ISO_CLR;
          state_d  = pwr_pkg::FSM_ACK;
          rsp_load = 1'b1;
        end
      end

      pwr_pkg::FSM_OFF_ISO_WAIT: begin
        if (tmr_done_i) begin
          step_o      = pwr_pkg::STEP_RST_ASSERT;
          tmr_start_o = 1'b1;
          tmr_count_o = RST_CNT;
          state_d     = pwr_pkg::FSM_OFF_RST_WAIT;
        end
      end

      pwr_pkg::FSM_OFF_RST_WAIT: begin
        if (tmr_done_i) begin
          step_o      = pwr_pkg::STEP_SW_OFF;
          tmr_start_o = 1'b1;
          tmr_count_o = ACK_CNT;
          state_d     = pwr_pkg::FSM_OFF_ACK_WAIT;
        end
      end

      pwr_pkg::FSM_OFF_ACK_WAIT: begin
        if (!dom_ack) begin
          state_d  = pwr_pkg::FSM_ACK;
          rsp_load = 1'b1;
        end else if (tmr_done_i) begin
          step_o   = pwr_pkg::STEP_OFF_SAFE;
          status_d = pwr_pkg::PWR_ST_TIMEOUT;
          state_d  = pwr_pkg::FSM_ACK;
          rsp_load = 1'b1;
        end
      end

      pwr_pkg::FSM_ACK: begin
        if (!req_i) begin
          state_d = pwr_pkg::FSM_IDLE;
        end
      end

      default: begin
        state_d = pwr_pkg::FSM_IDLE;
      end
    endcase
  end

  // Powered flag as it stands once this cycle's step is applied
  assign powered_d = dom_pwr && (step_o != pwr_pkg::STEP_OFF_SAFE) &&
                     (step_o != pwr_pkg::STEP_SW_OFF);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= pwr_pkg::FSM_IDLE;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      if (rsp_load) begin
        rsp_q.status  <= status_d;
        rsp_q.powered <= powered_d;
      end
    end
  end

  // Command is stable while req is high
  always_ff @(posedge clk_i) begin
    if (state_q == pwr_pkg::FSM_IDLE && req_i) begin
      cmd_q <= cmd_i;
    end
  end

  assign ack_o      = (state_q == pwr_pkg::FSM_ACK);
  assign rsp_o      = rsp_q;
  assign step_dom_o = cmd_q.domain;

  // Four-phase rule seen from the requester side
  ack_falls_after_req_low : assert property (
    @(posedge clk_i) disable iff (rst_i)
    $fell(ack_o) |-> !$past(req_i) && $past(req_i, 2)
  );

endmodule

`default_nettype wire

/* source/pwr_domain_ctrl.sv */
//////////////////////////////////////////////////
// Domain control bank
// Switch, iso, reset and retention lines per domain
// plus the switch acknowledge synchronizer
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module pwr_domain_ctrl (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  pwr_pkg::pwr_step_e           step_i,
  input  wire [`PWR_DOM_W-1:0]         dom_i,
  input  wire [`PWR_NUM_DOMAINS-1:0]   switch_ack_i,
  output logic [`PWR_NUM_DOMAINS-1:0]  ack_sync_o,
  output pwr_pkg::pwr_dom_ctrl_t       dom_ctrl_o
);

  pwr_pkg::pwr_dom_ctrl_t      ctrl_q;
  logic [`PWR_NUM_DOMAINS-1:0] ack_meta_q;
  logic [`PWR_NUM_DOMAINS-1:0] ack_sync_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Every domain off and safe
      ctrl_q.switch_en <= '0;
      ctrl_q.iso       <= '1;
      ctrl_q.rst_n     <= '0;
      ctrl_q.retentive <= '0;
    end else begin
      case (step_i)
        pwr_pkg::STEP_ISO_SET:     ctrl_q.iso[dom_i] <= 1'b1;
        pwr_pkg::STEP_ISO_CLR:     ctrl_q.iso[dom_i] <= 1'b0;
        pwr_pkg::STEP_RST_ASSERT:  ctrl_q.rst_n[dom_i] <= 1'b0;
        pwr_pkg::STEP_RST_RELEASE: ctrl_q.rst_n[dom_i] <= 1'b1;
        pwr_pkg::STEP_SW_ON:       ctrl_q.switch_en[dom_i] <= 1'b1;
        pwr_pkg::STEP_SW_OFF: begin
          // Retention cannot outlive the supply
          ctrl_q.switch_en[dom_i] <= 1'b0;
          ctrl_q.retentive[dom_i] <= 1'b0;
        end
        pwr_pkg::STEP_RET_SET:     ctrl_q.retentive[dom_i] <= 1'b1;
        pwr_pkg::STEP_RET_CLR:     ctrl_q.retentive[dom_i] <= 1'b0;
        pwr_pkg::STEP_OFF_SAFE: begin
          ctrl_q.switch_en[dom_i] <= 1'b0;
          ctrl_q.iso[dom_i]       <= 1'b1;
          ctrl_q.rst_n[dom_i]     <= 1'b0;
          ctrl_q.retentive[dom_i] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // Two-flop sync of the switch cell acks
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_meta_q <= '0;
      ack_sync_q <= '0;
    end else begin
      ack_meta_q <= switch_ack_i;
      ack_sync_q <= ack_meta_q;
    end
  end

  assign ack_sync_o = ack_sync_q;
  assign dom_ctrl_o = ctrl_q;

  // Unpowered domains stay isolated and in reset
  off_domain_is_safe : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (~ctrl_q.switch_en & (~ctrl_q.iso | ctrl_q.rst_n)) == '0
  );

  off_domain_not_retentive : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (~ctrl_q.switch_en & ctrl_q.retentive) == '0
  );

endmodule

`default_nettype wire

/* source/pwr_wait_timer.sv */
//////////////////////////////////////////////////
// Wait timer
// Down-counter for settle waits and ack timeout
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

module pwr_wait_timer (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   start_i,
  input  wire [`PWR_TMR_W-1:0]  count_i,
  output logic                  done_o
);

  logic [`PWR_TMR_W-1:0] cnt_q;
  logic                  load_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      load_q <= 1'b0;
    end else begin
      load_q <= start_i;
      if (start_i) begin
        cnt_q <= count_i;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // A fresh load hides the zero count for one cycle
  assign done_o = (cnt_q == '0) && !load_q;

endmodule

`default_nettype wire

/* source/pwr_pkg.sv */
//////////////////////////////////////////////////
// Power-gating controller types
// Command, response, domain lines and FSM states
//////////////////////////////////////////////////

`default_nettype none

`include "pwr_params.svh"

package pwr_pkg;

  typedef enum logic [1:0] {
    PWR_OP_OFF     = 2'd0,
    PWR_OP_ON      = 2'd1,
    PWR_OP_RET_SET = 2'd2,
    PWR_OP_RET_CLR = 2'd3
  } pwr_op_e;

  typedef enum logic [1:0] {
    PWR_ST_OK      = 2'd0,
    PWR_ST_TIMEOUT = 2'd1,
    PWR_ST_REFUSED = 2'd2
  } pwr_status_e;

  typedef struct packed {
    pwr_op_e                op;
    logic [`PWR_DOM_W-1:0]  domain;
  } pwr_cmd_t;

  typedef struct packed {
    pwr_status_e status;
    logic        powered;
  } pwr_rsp_t;

  // One bit per domain in each vector
  typedef struct packed {
    logic [`PWR_NUM_DOMAINS-1:0] switch_en;
    logic [`PWR_NUM_DOMAINS-1:0] iso;
    logic [`PWR_NUM_DOMAINS-1:0] rst_n;
    logic [`PWR_NUM_DOMAINS-1:0] retentive;
  } pwr_dom_ctrl_t;

  typedef enum logic [3:0] {
    STEP_NONE,
    STEP_ISO_SET,
    STEP_ISO_CLR,
    STEP_RST_ASSERT,
    STEP_RST_RELEASE,
    STEP_SW_ON,
    STEP_SW_OFF,
    STEP_RET_SET,
    STEP_RET_CLR,
    STEP_OFF_SAFE
  } pwr_step_e;

  typedef enum logic [3:0] {
    FSM_IDLE,
    FSM_DECIDE,
    FSM_ON_ACK_WAIT,
    FSM_ON_RST_WAIT,
    FSM_ON_ISO_WAIT,
    FSM_OFF_ISO_WAIT,
    FSM_OFF_RST_WAIT,
    FSM_OFF_ACK_WAIT,
    FSM_ACK
  } pwr_fsm_e;

endpackage

`default_nettype wire

/* source/pwr_params.svh */
//////////////////////////////////////////////////
// Power-gating controller constants
// Domain count, settle waits and ack timeout
//////////////////////////////////////////////////

`ifndef PWR_PARAMS_SVH
`define PWR_PARAMS_SVH

// External power domains
`define PWR_NUM_DOMAINS 4
`define PWR_DOM_W 2

// Settle waits in clock cycles
`define PWR_ISO_WAIT 4
`define PWR_RST_WAIT 4

// Switch acknowledge limit and timer width
`define PWR_ACK_TIMEOUT 64
`define PWR_TMR_W 7

`endif
